// File: include/proc_consts.svh
// Opcode, function-code and memory-size macros for the processor
`ifndef PROC_CONSTS_SVH
`define PROC_CONSTS_SVH

// Major opcodes, bits [15:11] of every instruction
`define OP_HALT   5'b00000
`define OP_NOP    5'b00001
`define OP_J      5'b00100
`define OP_ADDI   5'b01000
`define OP_SUBI   5'b01001
`define OP_XORI   5'b01010
`define OP_ANDNI  5'b01011
`define OP_BEQZ   5'b01100
`define OP_BNEZ   5'b01101
`define OP_ST     5'b10000
`define OP_LD     5'b10001
`define OP_LBI    5'b11000
`define OP_RRR    5'b11011

// Function codes of the register-format group
`define FN_ADD    2'b00
`define FN_SUB    2'b01
`define FN_XOR    2'b10
`define FN_ANDN   2'b11

// Memory depths in 16-bit words
`define IMEM_WORDS 256
`define DMEM_WORDS 256

`endif

// File: verilog/proc_pkg.sv
// Instruction union, control, load and retire structs, destination register helper
package proc_pkg;

    // Register format: op rs rt rd funct
    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rs;
        logic [2:0] rt;
        logic [2:0] rd;
        logic [1:0] funct;
    } rFmtT;

    // Immediate format: op rs rd imm5
    // imm8 is {rd, imm} and disp11 is {rs, rd, imm}
    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rs;
        logic [2:0] rd;
        logic [4:0] imm;
    } iFmtT;

    typedef union packed {
        rFmtT rFmt;
        iFmtT iFmt;
    } instrT;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_XOR,
        ALU_ANDN,
        ALU_PASSB
    } aluOpT;

    typedef enum logic [1:0] {
        IMM_S5,
        IMM_Z5,
        IMM_S8,
        IMM_S11
    } immKindT;

    typedef struct packed {
        logic    regWrite;
        logic    regDstRd;
        logic    aluSrcImm;
        logic    memRead;
        logic    memWrite;
        logic    memToReg;
        logic    branch;
        logic    branchNz;
        logic    jump;
        logic    halt;
        immKindT immKind;
        aluOpT   aluOp;
    } ctrlT;

    typedef struct packed {
        logic        valid;
        logic [7:0]  addr;
        logic [15:0] instr;
    } imemLoadT;

    typedef struct packed {
        logic        valid;
        logic [15:0] pc;
        logic        regWrite;
        logic [2:0]  dest;
        logic [15:0] wdata;
        logic        memWrite;
        logic [15:0] addr;
        logic [15:0] sdata;
    } retireT;

    // R format writes rd, LBI writes rs, everything else writes rd of the I view
    function automatic logic [2:0] destReg(instrT instr, ctrlT ctrl);
        if (ctrl.regDstRd) begin
            return instr.rFmt.rd;
        end
        if (ctrl.immKind == IMM_S8) begin
            return instr.iFmt.rs;
        end
        return instr.iFmt.rd;
    endfunction

endpackage

// File: verilog/fetch.sv
// Fetch stage with PC register, instruction memory and program load port
`include "proc_consts.svh"

module fetch
    import proc_pkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  imemLoadT    imemLoad,
    input  logic [15:0] nextPc,
    input  logic        halted,
    output logic [15:0] pc,
    output instrT       instr
);

    localparam int AW = $clog2(`IMEM_WORDS);

    logic [15:0] imem [`IMEM_WORDS];

    // Program load, allowed on any edge
    always_ff @(posedge clk) begin
        if (imemLoad.valid) begin
            imem[imemLoad.addr[AW-1:0]] <= imemLoad.instr;
        end
    end

    // PC holds once the core has halted
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc <= '0;
        end else if (!halted) begin
            pc <= nextPc;
        end
    end

    // Word addressed, low bits of the PC only
    assign instr = imem[pc[AW-1:0]];

endmodule

// File: verilog/control.sv
// Main control decoder with sticky halted and illegal-opcode error flags
`include "proc_consts.svh"

module control
    import proc_pkg::*;
(
    input  logic  clk,
    input  logic  rstN,
    input  instrT instr,
    output ctrlT  ctrl,
    output logic  halted,
    output logic  err
);

    logic illegalOp;

    always_comb begin
        ctrl      = '0;
        illegalOp = 1'b0;
        case (instr.rFmt.opcode)
            `OP_HALT: ctrl.halt = 1'b1;
            `OP_NOP: begin
            end
            `OP_ADDI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            `OP_SUBI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = ALU_SUB;
            end
            `OP_XORI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = ALU_XOR;
                ctrl.immKind   = IMM_Z5;
            end
            `OP_ANDNI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = ALU_ANDN;
                ctrl.immKind   = IMM_Z5;
            end
            // Base plus signed offset for both memory ops
            `OP_ST: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            `OP_LD: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.memToReg  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            `OP_BEQZ: begin
                ctrl.branch  = 1'b1;
                ctrl.immKind = IMM_S8;
            end
            `OP_BNEZ: begin
                ctrl.branch   = 1'b1;
                ctrl.branchNz = 1'b1;
                ctrl.immKind  = IMM_S8;
            end
            `OP_LBI: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = ALU_PASSB;
                ctrl.immKind   = IMM_S8;
            end
            `OP_J: begin
                ctrl.jump    = 1'b1;
                ctrl.immKind = IMM_S11;
            end
            `OP_RRR: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDstRd = 1'b1;
                case (instr.rFmt.funct)
                    `FN_ADD: ctrl.aluOp = ALU_ADD;
                    `FN_SUB: ctrl.aluOp = ALU_SUB;
                    `FN_XOR: ctrl.aluOp = ALU_XOR;
                    default: ctrl.aluOp = ALU_ANDN;
                endcase
            end
            default: illegalOp = 1'b1;
        endcase
    end

    // Both flags stick until reset; nothing executes after halt
    always_ff @(posedge clk) begin
        if (!rstN) begin
            halted <= 1'b0;
            err    <= 1'b0;
        end else if (!halted) begin
            if (ctrl.halt) begin
                halted <= 1'b1;
            end
            if (illegalOp) begin
                err <= 1'b1;
            end
        end
    end

endmodule

// File: verilog/decode.sv
// Register file, source and destination selection and immediate extension
module decode
    import proc_pkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  instrT       instr,
    input  ctrlT        ctrl,
    input  logic [15:0] writeData,
    output logic [15:0] readData1,
    output logic [15:0] readData2,
    output logic [15:0] immVal
);

    logic [15:0] regs [8];
    logic [2:0]  dest;
    logic [7:0]  imm8;
    logic [10:0] disp11;

    assign dest = destReg(instr, ctrl);

    // Second source rt of the R view shares its bits with the store-data rd of the I view
    assign readData1 = regs[instr.rFmt.rs];
    assign readData2 = regs[instr.rFmt.rt];

    // Wider immediates sit on the low bits of the I view
    assign imm8   = {instr.iFmt.rd, instr.iFmt.imm};
    assign disp11 = {instr.iFmt.rs, instr.iFmt.rd, instr.iFmt.imm};

    always_comb begin
        case (ctrl.immKind)
            IMM_S5:  immVal = {{11{instr.iFmt.imm[4]}}, instr.iFmt.imm};
            IMM_Z5:  immVal = {11'b0, instr.iFmt.imm};
            IMM_S8:  immVal = {{8{imm8[7]}}, imm8};
            default: immVal = {{5{disp11[10]}}, disp11};
        endcase
    end

    // Reads above see the old value on a same-cycle write
    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (ctrl.regWrite) begin
            regs[dest] <= writeData;
        end
    end

endmodule

// File: verilog/execute.sv
// ALU operand selection, ALU and branch flags
module execute
    import proc_pkg::*;
(
    input  logic [15:0] readData1,
    input  logic [15:0] readData2,
    input  logic [15:0] immVal,
    input  ctrlT        ctrl,
    output logic [15:0] aluRes,
    output logic        zero,
    output logic        ltz
);

    logic [15:0] opA;
    logic [15:0] opB;

    assign opA = readData1;
    assign opB = ctrl.aluSrcImm ? immVal : readData2;

    always_comb begin
        case (ctrl.aluOp)
            ALU_ADD:  aluRes = opA + opB;
            // Subtract is reversed in this ISA
            ALU_SUB:  aluRes = opB - opA;
            ALU_XOR:  aluRes = opA ^ opB;
            ALU_ANDN: aluRes = opA & ~opB;
            default:  aluRes = opB;
        endcase
    end

    // Branches test rs itself, not the ALU result
    assign zero = (readData1 == 16'd0);
    assign ltz  = readData1[15];

endmodule

// File: verilog/data_mem.sv
// Data memory with synchronous write and combinational read
`include "proc_consts.svh"

module data_mem
    import proc_pkg::*;
(
    input  logic        clk,
    input  logic        rstN,
    input  ctrlT        ctrl,
    input  logic [15:0] addr,
    input  logic [15:0] writeData,
    output logic [15:0] memData
);

    localparam int AW = $clog2(`DMEM_WORDS);

    logic [15:0] mem [`DMEM_WORDS];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < `DMEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else if (ctrl.memWrite) begin
            mem[addr[AW-1:0]] <= writeData;
        end
    end

    // Only loads see memory contents
    assign memData = ctrl.memRead ? mem[addr[AW-1:0]] : 16'd0;

endmodule

// File: verilog/pc_control.sv
// Next-PC selection for sequential flow, branches, jumps and halt
module pc_control
    import proc_pkg::*;
(
    input  logic [15:0] pc,
    input  logic [15:0] immVal,
    input  ctrlT        ctrl,
    input  logic        zero,
    output logic [15:0] nextPc
);

    logic [15:0] seqPc;
    logic        brTaken;

    assign seqPc = pc + 16'd1;

    // BEQZ on zero, BNEZ on nonzero
    assign brTaken = ctrl.branch && (ctrl.branchNz ? !zero : zero);

    always_comb begin
        if (ctrl.halt) begin
            nextPc = pc;
        end else if (ctrl.jump || brTaken) begin
            // Displacement is relative to the following instruction
            nextPc = seqPc + immVal;
        end else begin
            nextPc = seqPc;
        end
    end

endmodule

// File: verilog/proc.sv
// Processor top level with stage instances, writeback mux and retire trace
module proc
    import proc_pkg::*;
(
    input  logic     clk,
    input  logic     rstN,
    input  imemLoadT imemLoad,
    output retireT   retire,
    output logic     halt,
    output logic     err
);

    logic [15:0] pc;
    logic [15:0] nextPc;
    instrT       instr;
    ctrlT        ctrl;
    logic [15:0] readData1;
    logic [15:0] readData2;
    logic [15:0] immVal;
    logic [15:0] aluRes;
    logic        zero;
    logic [15:0] memData;
    logic [15:0] writeData;
    logic        ctrlErr;

    fetch fetch0 (.clk(clk), .rstN(rstN), .imemLoad(imemLoad), .nextPc(nextPc),
                  .halted(halt), .pc(pc), .instr(instr));

    control control0 (.clk(clk), .rstN(rstN), .instr(instr), .ctrl(ctrl),
                      .halted(halt), .err(ctrlErr));

    decode decode0 (.clk(clk), .rstN(rstN), .instr(instr), .ctrl(ctrl),
                    .writeData(writeData), .readData1(readData1),
                    .readData2(readData2), .immVal(immVal));

    // Sign flag is not needed by the branches of this subset
    execute exec0 (.readData1(readData1), .readData2(readData2), .immVal(immVal),
                   .ctrl(ctrl), .aluRes(aluRes), .zero(zero), .ltz());

    data_mem memory0 (.clk(clk), .rstN(rstN), .ctrl(ctrl), .addr(aluRes),
                      .writeData(readData2), .memData(memData));

    pc_control pcControl0 (.pc(pc), .immVal(immVal), .ctrl(ctrl), .zero(zero),
                           .nextPc(nextPc));

    // Writeback
    assign writeData = ctrl.memToReg ? memData : aluRes;

    // Control is the only error source in this subset
    assign err = ctrlErr;

    always_comb begin
        retire.valid    = rstN && !halt;
        retire.pc       = pc;
        retire.regWrite = ctrl.regWrite;
        retire.dest     = destReg(instr, ctrl);
        retire.wdata    = writeData;
        retire.memWrite = ctrl.memWrite;
        retire.addr     = aluRes;
        retire.sdata    = readData2;
    end

endmodule

// File: test/proc_assert.sv
// Concurrent assertions on halt, retire and reset behavior of the processor, with their bind
`include "proc_consts.svh"

module proc_assert
    import proc_pkg::*;
(
    input logic   clk,
    input logic   rstN,
    input instrT  instr,
    input retireT retire,
    input logic   halt,
    input logic   err
);

    int failures = 0;

    // Halt is sticky until the next reset
    haltSticky: assert property (@(posedge clk) (rstN && halt) |=> (halt || !rstN))
        else begin
            $error("halt fell while the core was out of reset");
            failures++;
        end

    // A retired HALT raises halt and ends retiring at the following edge
    retireAfterHalt: assert property (@(posedge clk)
        (retire.valid && instr.rFmt.opcode == `OP_HALT) |=> (!rstN || (halt && !retire.valid)))
        else begin
            $error("an instruction retired after a HALT or halt did not rise");
            failures++;
        end

    // Flags are cleared by the first reset edge, so check from the second one on
    resetQuiet: assert property (@(posedge clk)
        (!rstN ##1 !rstN) |-> (!retire.valid && !halt && !err))
        else begin
            $error("retire, halt or err was high during reset");
            failures++;
        end

endmodule

bind proc proc_assert procAssert_i (.clk(clk), .rstN(rstN), .instr(instr),
                                    .retire(retire), .halt(halt), .err(err));

// File: test/proc_tb.sv
// Random program testbench with instruction-set model, checker and watchdog
`include "proc_consts.svh"

module proc_tb
    import proc_pkg::*;
();

    localparam int PERIOD    = 8;
    localparam int NUM_PROGS = 8;

    // Opcode mixes per program kind, five bits per slot
    localparam logic [29:0] ALU_OPS = {`OP_RRR, `OP_ADDI, `OP_SUBI, `OP_XORI, `OP_ANDNI, `OP_LBI};
    localparam logic [29:0] MEM_OPS = {`OP_LBI, `OP_ST, `OP_LD, `OP_ADDI, `OP_ST, `OP_LD};
    localparam logic [29:0] BR_OPS  = {`OP_LBI, `OP_BEQZ, `OP_BNEZ, `OP_J, `OP_XORI, `OP_NOP};
    localparam logic [29:0] MIX_OPS = {`OP_RRR, `OP_LD, `OP_ST, `OP_BNEZ, `OP_SUBI, `OP_LBI};

    logic     clk = 1'b0;
    logic     rstN;
    imemLoadT imemLoad;
    retireT   retire;
    logic     halt;
    logic     err;

    integer      seed = 32'he60e57d3;
    int          errors = 0;
    int          progNum;
    int          progLen;
    logic [15:0] prog [256];
    logic [15:0] regs [8];
    logic [15:0] dmem [256];
    logic [15:0] mpc;
    logic        modelHalted;
    logic        expErr;

    proc dut_i (.clk(clk), .rstN(rstN), .imemLoad(imemLoad), .retire(retire),
                .halt(halt), .err(err));

    always #(PERIOD / 2) clk = ~clk;

    task automatic checkValue(string name, logic [15:0] expected, logic [15:0] actual);
        if (expected !== actual) begin
            errors++;
            $display("error prog%0d %s: expected %h, actual %h", progNum, name, expected, actual);
        end
    endtask

    // Branches and jumps only go forward and never past the final HALT
    function automatic logic [15:0] makeInstr(int kind, int idx);
        logic [29:0] mix;
        logic [4:0]  op;
        logic [10:0] body;
        int          d;
        mix  = kind == 0 ? ALU_OPS : kind == 1 ? MEM_OPS : kind == 2 ? BR_OPS : MIX_OPS;
        op   = mix[({$random(seed)} % 6) * 5 +: 5];
        body = $random(seed);
        d    = {$random(seed)} % (progLen - 1 - idx);
        if (kind == 3 && idx == progLen / 2) begin
            return {5'b00010, body};
        end
        case (op)
            `OP_BEQZ, `OP_BNEZ: return {op, body[10:8], 8'(d)};
            `OP_J:              return {op, 11'(d)};
            // Small values keep load and store addresses close together
            `OP_LBI:            return kind == 1 ? {op, body[10:8], 5'd0, body[2:0]} : {op, body};
            default:            return {op, body};
        endcase
    endfunction

    task automatic stepModel();
        logic [15:0] ir;
        logic [15:0] a;
        logic [15:0] b;
        logic [15:0] s5;
        logic [15:0] z5;
        logic [15:0] s8;
        logic [15:0] val;
        logic [15:0] ad;
        logic [15:0] npc;
        logic [2:0]  dst;
        logic        wr;
        logic        mw;
        ir  = prog[mpc[7:0]];
        a   = regs[ir[10:8]];
        b   = regs[ir[7:5]];
        s5  = {{11{ir[4]}}, ir[4:0]};
        z5  = {11'd0, ir[4:0]};
        s8  = {{8{ir[7]}}, ir[7:0]};
        ad  = a + s5;
        dst = ir[7:5];
        val = 16'd0;
        wr  = 1'b0;
        mw  = 1'b0;
        npc = mpc + 16'd1;
        case (ir[15:11])
            `OP_RRR: begin
                wr  = 1'b1;
                dst = ir[4:2];
                case (ir[1:0])
                    `FN_ADD: val = a + b;
                    `FN_SUB: val = b - a;
                    `FN_XOR: val = a ^ b;
                    default: val = a & ~b;
                endcase
            end
            `OP_ADDI:  {wr, val} = {1'b1, a + s5};
            `OP_SUBI:  {wr, val} = {1'b1, s5 - a};
            `OP_XORI:  {wr, val} = {1'b1, a ^ z5};
            `OP_ANDNI: {wr, val} = {1'b1, a & ~z5};
            `OP_LD:    {wr, val} = {1'b1, dmem[ad[7:0]]};
            `OP_ST:    mw = 1'b1;
            `OP_LBI:   {wr, dst, val} = {1'b1, ir[10:8], s8};
            `OP_BEQZ:  npc = (a == 16'd0) ? npc + s8 : npc;
            `OP_BNEZ:  npc = (a != 16'd0) ? npc + s8 : npc;
            `OP_J:     npc = npc + {{5{ir[10]}}, ir[10:0]};
            `OP_HALT:  {modelHalted, npc} = {1'b1, mpc};
            `OP_NOP: begin
            end
            // Anything else behaves as a NOP and raises err
            default:   expErr = 1'b1;
        endcase
        checkValue("pc", mpc, retire.pc);
        checkValue("regWrite", wr, retire.regWrite);
        checkValue("memWrite", mw, retire.memWrite);
        if (wr) begin
            checkValue("dest", dst, retire.dest);
            checkValue("wdata", val, retire.wdata);
            regs[dst] = val;
        end
        if (mw) begin
            checkValue("store addr", ad, retire.addr);
            checkValue("store data", b, retire.sdata);
            dmem[ad[7:0]] = b;
        end
        mpc = npc;
    endtask

    task automatic runProgram(int kind);
        int hold;
        progLen = 12 + {$random(seed)} % 16;
        for (int i = 0; i < progLen - 1; i++) begin
            prog[i] = makeInstr(kind, i);
        end
        prog[progLen - 1] = {`OP_HALT, 11'd0};
        for (int i = 0; i < 8; i++) begin
            regs[i] = 16'd0;
        end
        for (int i = 0; i < 256; i++) begin
            dmem[i] = 16'd0;
        end
        mpc         = 16'd0;
        modelHalted = 1'b0;
        expErr      = 1'b0;
        // Program goes in while the core sits in reset
        hold = (progLen + 1 > 8) ? progLen + 1 : 8;
        for (int c = 0; c < hold; c++) begin
            @(posedge clk);
            #1;
            rstN = 1'b0;
            if (c < progLen) begin
                imemLoad = {1'b1, 8'(c), prog[c]};
            end else begin
                imemLoad = '0;
            end
        end
        @(posedge clk);
        #1;
        rstN = 1'b1;
        @(negedge clk);
        checkValue("halt after reset", 0, halt);
        checkValue("err after reset", 0, err);
        while (!modelHalted) begin
            if (!retire.valid) begin
                errors++;
                $display("prog%0d: the processor stopped retiring at pc %h before HALT",
                         progNum, retire.pc);
                break;
            end
            stepModel();
            @(negedge clk);
        end
        repeat (20) begin
            checkValue("halt held", 1, halt);
            checkValue("retire after halt", 0, retire.valid);
            @(negedge clk);
        end
        checkValue("err flag", expErr, err);
    endtask

    initial begin
        rstN     = 1'b0;
        imemLoad = '0;
        for (progNum = 0; progNum < NUM_PROGS; progNum++) begin
            runProgram(progNum % 4);
        end
        $display("errors: %0d from checks, %0d from assertions",
                 errors, dut_i.procAssert_i.failures);
        if (errors == 0 && dut_i.procAssert_i.failures == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // Watchdog sized for the longest possible program per run
    initial begin
        #(NUM_PROGS * (256 + 16) * PERIOD);
        $display("timeout: the run did not reach its end and the processor appears to hang");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// File: proc.f
+incdir+include
verilog/proc_pkg.sv
verilog/fetch.sv
verilog/control.sv
verilog/decode.sv
verilog/execute.sv
verilog/data_mem.sv
verilog/pc_control.sv
verilog/proc.sv
test/proc_assert.sv
test/proc_tb.sv
